// File: processor.f
+incdir+test
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/control_unit.sv
logic/register_bank.sv
logic/alu.sv
logic/flag_test.sv
logic/data_memory.sv
logic/processor.sv
test/processor_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f processor.f --top-module processor_tb -o sim_processor

output=$(./obj_dir/sim_processor)
echo "$output"

if echo "$output" | grep -q "^PASS: all tests$"; then
	exit 0
else
	exit 1
fi

// File: test/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

word_t prog [$];
word_t m_regs [32];
word_t m_mem [256];
logic m_o;
logic m_s;
logic m_c;
logic m_z;
bit mem_valid [256];
logic [7:0] valid_addr [$];	// data words that hold a known value
pc_t exp_pc [$];
logic exp_we [$];
reg_addr_t exp_waddr [$];
word_t exp_wdata [$];

function automatic word_t enc_r(reg_addr_t rd, reg_addr_t ra, reg_addr_t rb, alu_op_t op);
	return {OP_RALU, rd, ra, rb, 7'd0, op};
endfunction

function automatic word_t enc_i(opcode_t op, reg_addr_t rd, reg_addr_t ra, logic [15:0] imm);
	return {op, rd, ra, imm};
endfunction

function automatic word_t enc_s(reg_addr_t ra, reg_addr_t rb, logic [10:0] off);
	return {OP_STORE, 5'd0, ra, rb, off};
endfunction

function automatic word_t enc_b(cond_t cond, logic [10:0] off);
	return {OP_BRANCH, 5'd0, 5'd0, 1'b0, cond, 1'b0, off};
endfunction

// 0 ralu, 1 ialu, 2 store, 3 load, 4 branch, 5 jal
function automatic int pick_kind(int mix);
	int r;
	r = $urandom_range(0, 9);
	case (mix)
		0: return (r < 5) ? 0 : 1;
		1: return (r < 2) ? 0 : (r < 3) ? 1 : (r < 6) ? 2 : 3;
		2: return (r < 3) ? 0 : (r < 5) ? 1 : 4;
		3: return (r < 6) ? (r & 1) : 5;
		default: return (r < 3) ? 0 : (r == 3) ? 1 : (r == 4) ? 2 : (r == 5) ? 3 : (r < 8) ? 4 : 5;
	endcase
endfunction

task automatic gen_program(input int mix);
	int n;
	int maxoff;
	logic [7:0] avail [$];
	logic [7:0] ad;
	reg_addr_t rd;
	reg_addr_t ra;
	reg_addr_t rb;
	prog.delete();
	avail = valid_addr;
	n = $urandom_range(40, 80);
	for (int i = 1; i <= 4; i++)
		prog.push_back(enc_i(OP_IALU, reg_addr_t'(i), 5'd0, 16'($urandom)));
	for (int i = 1; i <= 4; i++) begin	// seed some data words for the loads
		ad = 8'($urandom);
		avail.push_back(ad);
		prog.push_back(enc_s(5'd0, reg_addr_t'(i), {3'd0, ad}));
	end
	while (prog.size() < n - 1) begin
		rd = 5'($urandom);
		ra = 5'($urandom);
		rb = 5'($urandom);
		maxoff = n - 1 - prog.size();	// forward only and at most onto the halt
		case (pick_kind(mix))
			0: prog.push_back(enc_r(rd, ra, rb, alu_op_t'(4'($urandom_range(0, 7)))));
			1: prog.push_back(enc_i(OP_IALU, rd, ra, 16'($urandom)));
			2: prog.push_back(enc_s(5'd0, rb, {3'd0, 8'($urandom)}));
			3: prog.push_back(enc_i(OP_LOAD, rd, 5'd0,
				{8'd0, avail[$urandom_range(0, avail.size() - 1)]}));
			4: prog.push_back(enc_b(cond_t'(3'($urandom)), 11'($urandom_range(1, maxoff))));
			default: prog.push_back(enc_i(OP_JAL, rd, 5'd0, 16'($urandom_range(1, maxoff))));
		endcase
	end
	prog.push_back({OP_HALT, 26'd0});
endtask

task automatic alu_model(input alu_op_t op, input word_t a, input word_t b,
		output word_t res, output logic o, output logic c);
	int sh;
	longint wide;
	sh = int'(b[4:0]);
	o = 1'b0;
	c = 1'b0;
	case (op)
		ALU_ADD: begin
			{c, res} = {1'b0, a} + {1'b0, b};
			wide = longint'($signed(a)) + longint'($signed(b));
			o = (wide != longint'($signed(res)));	// signed result out of range
		end
		ALU_SUB: begin
			res = a - b;
			c = (a >= b);	// no borrow
			wide = longint'($signed(a)) - longint'($signed(b));
			o = (wide != longint'($signed(res)));
		end
		ALU_AND: res = a & b;
		ALU_OR:  res = a | b;
		ALU_XOR: res = a ^ b;
		ALU_SHL: begin
			res = a << sh;
			c = (sh == 0) ? 1'b0 : a[32 - sh];
		end
		ALU_SHR: begin
			res = a >> sh;
			c = (sh == 0) ? 1'b0 : a[sh - 1];
		end
		default: res = b;
	endcase
endtask

function automatic logic cond_holds(cond_t cnd);
	case (cnd)
		COND_AL: return 1'b1;
		COND_EQ: return m_z;
		COND_NE: return !m_z;
		COND_LT: return m_s != m_o;
		COND_CS: return m_c;
		COND_VS: return m_o;
		COND_MI: return m_s;
		default: return 1'b0;
	endcase
endfunction

task automatic run_model();
	pc_t pc;
	pc_t next;
	word_t ins;
	word_t a;
	word_t b;
	word_t imm;
	word_t res;
	word_t addr_w;
	logic o;
	logic c;
	logic we;
	opcode_t op;
	reg_addr_t rd;
	for (int i = 0; i < 32; i++)
		m_regs[i] = '0;
	{m_o, m_s, m_c, m_z} = 4'b0;
	exp_pc.delete();
	exp_we.delete();
	exp_waddr.delete();
	exp_wdata.delete();
	pc = '0;
	for (int step = 0; step < 200; step++) begin
		ins = prog[pc];
		op = ins[31:26];
		rd = ins[25:21];
		a = m_regs[ins[20:16]];
		b = m_regs[ins[15:11]];
		imm = {{16{ins[15]}}, ins[15:0]};
		next = pc + 1;
		we = 1'b0;
		res = '0;
		exp_pc.push_back(pc);
		case (op)
			OP_RALU, OP_IALU: begin
				if (op == OP_RALU)
					alu_model(alu_op_t'(ins[3:0]), a, b, res, o, c);
				else
					alu_model(ALU_ADD, a, imm, res, o, c);
				{m_o, m_s, m_c, m_z} = {o, res[31], c, res == '0};
				we = 1'b1;
			end
			OP_LOAD: begin
				addr_w = a + imm;
				res = m_mem[addr_w[7:0]];
				we = 1'b1;
			end
			OP_STORE: begin
				addr_w = a + {{21{ins[10]}}, ins[10:0]};
				m_mem[addr_w[7:0]] = b;
				if (!mem_valid[addr_w[7:0]])
					valid_addr.push_back(addr_w[7:0]);
				mem_valid[addr_w[7:0]] = 1'b1;
			end
			OP_BRANCH: if (cond_holds(cond_t'(ins[14:12])))
				next = pc + {{21{ins[10]}}, ins[10:0]};
			OP_JAL: begin
				res = pc + 1;
				we = 1'b1;
				next = pc + imm;
			end
			default: ;
		endcase
		we = we && (rd != '0);
		exp_we.push_back(we);
		exp_waddr.push_back(rd);
		exp_wdata.push_back(res);
		if (op == OP_HALT)
			break;
		if (we)
			m_regs[rd] = res;
		pc = next;
	end
endtask

`endif

// File: test/processor_tb.sv
`timescale 1ns/1ps

module processor_tb;
	import cpu_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int MAX_LEN = 80;
	localparam int RESET_CYCLES = 8;
	localparam int WATCHDOG_NS = NUM_TESTS * MAX_LEN * 5 * 10 * 2 + NUM_TESTS * RESET_CYCLES * 10;

	logic CLK;
	logic rst_n;
	logic run;
	logic prog_we;
	pc_t prog_addr;
	word_t prog_data;
	logic retire;
	pc_t retire_pc;
	logic rf_we;
	reg_addr_t rf_waddr;
	word_t rf_wdata;
	logic halted;

	int errors = 0;
	int tests_failed = 0;
	pc_t act_pc [$];
	logic act_we [$];
	reg_addr_t act_waddr [$];
	word_t act_wdata [$];

	`include "cpu_model.svh"

	processor UUT (.CLK(CLK), .rst_n(rst_n), .run(run), .prog_we(prog_we),
		.prog_addr(prog_addr), .prog_data(prog_data), .retire(retire),
		.retire_pc(retire_pc), .rf_we(rf_we), .rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata), .halted(halted));

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		if (retire === 1'b1) begin	// retire trace
			act_pc.push_back(retire_pc);
			act_we.push_back(rf_we);
			act_waddr.push_back(rf_waddr);
			act_wdata.push_back(rf_wdata);
		end
	end

	task automatic apply_reset();
		rst_n = 1'b0;
		run = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 rst_n = 1'b1;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge CLK);
			#1 prog_we = 1'b1;
			prog_addr = pc_t'(i);
			prog_data = prog[i];
		end
		@(posedge CLK);
		#1 prog_we = 1'b0;
	endtask

	task automatic clear_trace();
		act_pc.delete();
		act_we.delete();
		act_waddr.delete();
		act_wdata.delete();
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed, %0d errors", name, errors - errs_before);
			tests_failed++;
		end
	endtask

	task automatic check_idle();
		int errs_before;
		errs_before = errors;
		apply_reset();
		clear_trace();
		gen_program(4);
		load_program();	// run stays low so nothing executes
		for (int i = 0; i < 20; i++) begin
			@(posedge CLK);
			#1;
			if (retire !== 1'b0 || halted !== 1'b0) begin
				$display("[ERROR] idle: retire/halted expected 0/0 actual %b/%b",
					retire, halted);
				errors++;
			end
		end
		if (act_pc.size() != 0) begin
			$display("[ERROR] idle: retire count expected 0 actual %0d", act_pc.size());
			errors++;
		end
		finish_test("idle", errs_before);
	endtask

	task automatic run_program(input string name, input int mix);
		int errs_before;
		int cycles;
		int n;
		errs_before = errors;
		apply_reset();
		gen_program(mix);
		load_program();
		run_model();
		clear_trace();
		run = 1'b1;
		cycles = 0;
		while (halted !== 1'b1 && cycles < prog.size() * 5 * 2) begin
			@(posedge CLK);
			#1;
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("[ERROR] %s: halted never rose", name);
			errors++;
		end
		n = act_pc.size();
		repeat (20) @(posedge CLK);
		#1 run = 1'b0;
		if (act_pc.size() != n) begin
			$display("[ERROR] %s: retires after halt expected 0 actual %0d",
				name, act_pc.size() - n);
			errors++;
		end
		if (n != exp_pc.size()) begin
			$display("[ERROR] %s: retire count expected %0d actual %0d", name, exp_pc.size(), n);
			errors++;
		end
		for (int i = 0; i < n && i < exp_pc.size(); i++) begin
			if (act_pc[i] !== exp_pc[i]) begin
				$display("[ERROR] %s: retire %0d pc expected %0d actual %0d",
					name, i, exp_pc[i], act_pc[i]);
				errors++;
			end else if (act_we[i] !== exp_we[i]) begin
				$display("[ERROR] %s: retire %0d rf_we expected %0b actual %0b",
					name, i, exp_we[i], act_we[i]);
				errors++;
			end else if (exp_we[i] && (act_waddr[i] !== exp_waddr[i] ||
					act_wdata[i] !== exp_wdata[i])) begin
				$display("[ERROR] %s: retire %0d write expected r%0d=%h actual r%0d=%h", name,
					i, exp_waddr[i], exp_wdata[i], act_waddr[i], act_wdata[i]);
				errors++;
			end
		end
		finish_test(name, errs_before);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		void'($urandom(32'h315e));
		rst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		check_idle();
		run_program("alu", 0);
		run_program("load_store", 1);
		run_program("branch", 2);
		run_program("jal", 3);
		run_program("mixed", 4);
		$display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: logic/processor.sv
`timescale 1ns/1ps

module processor (
	input  logic CLK,
	input  logic rst_n,
	input  logic run,
	input  logic prog_we,
	input  cpu_pkg::pc_t prog_addr,
	input  cpu_pkg::word_t prog_data,
	output logic retire,
	output cpu_pkg::pc_t retire_pc,
	output logic rf_we,
	output cpu_pkg::reg_addr_t rf_waddr,
	output cpu_pkg::word_t rf_wdata,
	output logic halted
);
	import cpu_pkg::*;

	word_t instr;
	pc_t pc_plus1;
	logic pc_we;
	logic ir_we;
	logic take_branch;
	logic flags_we;
	alu_op_t alu_op;
	logic use_imm;
	word_t imm;
	logic dm_we;
	logic rf_write;
	wb_sel_t wb_sel;
	word_t rd_a;
	word_t rd_b;
	word_t alu_result;
	logic alu_o;
	logic alu_s;
	logic alu_c;
	logic alu_z;
	logic take_cond;
	word_t dm_q;

	fetch_unit u_fetch (.CLK(CLK), .rst_n(rst_n), .pc_we(pc_we), .take_branch(take_branch),
		.branch_offset(imm), .prog_we(prog_we), .prog_addr(prog_addr),
		.prog_data(prog_data), .ir_we(ir_we), .instr(instr), .pc(retire_pc),
		.pc_plus1(pc_plus1));

	control_unit u_ctrl (.CLK(CLK), .rst_n(rst_n), .run(run), .instr(instr),
		.take_cond(take_cond), .pc_we(pc_we), .ir_we(ir_we), .branch(take_branch),
		.flags_we(flags_we), .alu_op(alu_op), .use_imm(use_imm), .imm(imm),
		.dm_we(dm_we), .rf_write(rf_write), .wb_sel(wb_sel), .retire(retire),
		.halted(halted));

	register_bank u_regs (.CLK(CLK), .rst_n(rst_n), .ra(instr[20:16]), .rb(instr[15:11]),
		.rd(instr[25:21]), .rf_write(rf_write), .wb_sel(wb_sel), .alu_result(alu_result),
		.dm_q(dm_q), .pc_plus1(pc_plus1), .rd_a(rd_a), .rd_b(rd_b), .we(rf_we),
		.waddr(rf_waddr), .wdata(rf_wdata));

	alu u_alu (.a(rd_a), .b(rd_b), .imm(imm), .use_imm(use_imm), .op(alu_op),
		.result(alu_result), .o(alu_o), .s(alu_s), .c(alu_c), .z(alu_z));

	flag_test u_flags (.CLK(CLK), .rst_n(rst_n), .flags_we(flags_we), .o(alu_o),
		.s(alu_s), .c(alu_c), .z(alu_z), .cond(cond_t'(instr[14:12])),
		.take_cond(take_cond));

	data_memory u_dmem (.CLK(CLK), .we(dm_we), .addr(alu_result[DMEM_AW-1:0]),
		.wdata(rd_b), .q(dm_q));

endmodule

// File: logic/data_memory.sv
`timescale 1ns/1ps

module data_memory (
	input  logic CLK,
	input  logic we,
	input  logic [cpu_pkg::DMEM_AW-1:0] addr,
	input  cpu_pkg::word_t wdata,
	output cpu_pkg::word_t q
);
	import cpu_pkg::*;

	word_t mem [2**DMEM_AW];

	// address is stable from exec on, so q holds the load data in write-back
	always_ff @(posedge CLK) begin
		if (we)
			mem[addr] <= wdata;
		q <= mem[addr];
	end

endmodule

// File: logic/flag_test.sv
`timescale 1ns/1ps

module flag_test (
	input  logic CLK,
	input  logic rst_n,
	input  logic flags_we,
	input  logic o,
	input  logic s,
	input  logic c,
	input  logic z,
	input  cpu_pkg::cond_t cond,
	output logic take_cond
);
	import cpu_pkg::*;

	logic f_o;
	logic f_s;
	logic f_c;
	logic f_z;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			f_o <= 1'b0;
			f_s <= 1'b0;
			f_c <= 1'b0;
			f_z <= 1'b0;
		end else if (flags_we) begin
			f_o <= o;
			f_s <= s;
			f_c <= c;
			f_z <= z;
		end
	end

	always_comb begin
		case (cond)
			COND_AL: take_cond = 1'b1;
			COND_EQ: take_cond = f_z;
			COND_NE: take_cond = !f_z;
			COND_LT: take_cond = f_s ^ f_o;	// signed less than
			COND_CS: take_cond = f_c;
			COND_VS: take_cond = f_o;
			COND_MI: take_cond = f_s;
			default: take_cond = 1'b0;
		endcase
	end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::word_t a,
	input  cpu_pkg::word_t b,
	input  cpu_pkg::word_t imm,
	input  logic use_imm,
	input  cpu_pkg::alu_op_t op,
	output cpu_pkg::word_t result,
	output logic o,
	output logic s,
	output logic c,
	output logic z
);
	import cpu_pkg::*;

	word_t opb;
	logic [4:0] sh;
	logic [32:0] sum;
	logic [32:0] shl;
	logic [32:0] shr;

	assign opb = use_imm ? imm : b;
	assign sh  = opb[4:0];
	assign shl = {1'b0, a} << sh;	// msb is the last bit shifted out
	assign shr = {a, 1'b0} >> sh;	// lsb is the last bit shifted out

	always_comb begin
		sum = '0;
		result = '0;
		c = 1'b0;
		o = 1'b0;
		case (op)
			ALU_ADD: begin
				sum = {1'b0, a} + {1'b0, opb};
				result = sum[31:0];
				c = sum[32];
				o = (a[31] == opb[31]) && (result[31] != a[31]);
			end
			ALU_SUB: begin
				sum = {1'b0, a} + {1'b0, ~opb} + 33'd1;
				result = sum[31:0];
				c = sum[32];	// set when there is no borrow
				o = (a[31] != opb[31]) && (result[31] != a[31]);
			end
			ALU_AND: result = a & opb;
			ALU_OR:  result = a | opb;
			ALU_XOR: result = a ^ opb;
			ALU_SHL: begin
				result = shl[31:0];
				c = shl[32];
			end
			ALU_SHR: begin
				result = shr[32:1];
				c = shr[0];
			end
			ALU_PASSB: result = opb;
			default: result = '0;
		endcase
	end

	assign s = result[31];
	assign z = (result == '0);

endmodule

// File: logic/register_bank.sv
`timescale 1ns/1ps

module register_bank (
	input  logic CLK,
	input  logic rst_n,
	input  cpu_pkg::reg_addr_t ra,
	input  cpu_pkg::reg_addr_t rb,
	input  cpu_pkg::reg_addr_t rd,
	input  logic rf_write,
	input  cpu_pkg::wb_sel_t wb_sel,
	input  cpu_pkg::word_t alu_result,
	input  cpu_pkg::word_t dm_q,
	input  cpu_pkg::pc_t pc_plus1,
	output cpu_pkg::word_t rd_a,
	output cpu_pkg::word_t rd_b,
	output logic we,
	output cpu_pkg::reg_addr_t waddr,
	output cpu_pkg::word_t wdata
);
	import cpu_pkg::*;

	word_t regs [32];

	assign we = rf_write && (rd != '0);	// writes to r0 are dropped
	assign waddr = rd;

	always_comb begin
		case (wb_sel)
			WB_MEM:  wdata = dm_q;
			WB_LINK: wdata = pc_plus1;	// return address
			default: wdata = alu_result;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	assign rd_a = regs[ra];
	assign rd_b = regs[rb];

	a_r0_stays_zero: assert property (@(posedge CLK) disable iff (!rst_n)
		(rf_write && rd == '0) |=> (regs[0] == '0));

endmodule

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic CLK,
	input  logic rst_n,
	input  logic run,
	input  cpu_pkg::word_t instr,
	input  logic take_cond,
	output logic pc_we,
	output logic ir_we,
	output logic branch,
	output logic flags_we,
	output cpu_pkg::alu_op_t alu_op,
	output logic use_imm,
	output cpu_pkg::word_t imm,
	output logic dm_we,
	output logic rf_write,
	output cpu_pkg::wb_sel_t wb_sel,
	output logic retire,
	output logic halted
);
	import cpu_pkg::*;

	state_t state;
	state_t state_nx;
	opcode_t op;
	logic is_alu;
	logic is_mem;
	logic short_off;

	assign op = instr[31:26];
	assign is_alu = (op == OP_RALU) || (op == OP_IALU);
	assign is_mem = (op == OP_LOAD) || (op == OP_STORE);
	assign short_off = (op == OP_STORE) || (op == OP_BRANCH);	// [14:11] taken by rb or cond

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			state <= S_IDLE;
		else
			state <= state_nx;
	end

	always_comb begin
		state_nx = state;
		case (state)
			S_IDLE:   if (run) state_nx = S_FETCH;
			S_FETCH:  state_nx = S_DECODE;
			S_DECODE: state_nx = S_EXEC;
			S_EXEC:   state_nx = is_mem ? S_MEM : S_WB;
			S_MEM:    state_nx = S_WB;
			S_WB: begin
				if (op == OP_HALT)
					state_nx = S_HALT;
				else if (run)
					state_nx = S_FETCH;	// next instruction, no gap
				else
					state_nx = S_IDLE;
			end
			default:  state_nx = state;	// halt holds until reset
		endcase
	end

	assign ir_we    = (state == S_FETCH);
	assign flags_we = (state == S_EXEC) && is_alu;
	assign dm_we    = (state == S_MEM) && (op == OP_STORE);
	assign retire   = (state == S_WB);
	assign pc_we    = retire && (op != OP_HALT);
	assign rf_write = retire && (is_alu || (op == OP_LOAD) || (op == OP_JAL));
	assign halted   = (state == S_HALT);

	assign alu_op  = (op == OP_RALU) ? alu_op_t'(instr[3:0]) : ALU_ADD;
	assign use_imm = (op != OP_RALU);
	assign imm     = short_off ? {{21{instr[10]}}, instr[10:0]} : {{16{instr[15]}}, instr[15:0]};
	assign branch  = (op == OP_JAL) || ((op == OP_BRANCH) && take_cond);

	always_comb begin
		case (op)
			OP_LOAD: wb_sel = WB_MEM;
			OP_JAL:  wb_sel = WB_LINK;
			default: wb_sel = WB_ALU;
		endcase
	end

	a_retire_after_exec: assert property (@(posedge CLK) disable iff (!rst_n)
		retire |-> $past(state) inside {S_EXEC, S_MEM});

	a_store_then_retire: assert property (@(posedge CLK) disable iff (!rst_n)
		dm_we |=> retire);

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic CLK,
	input  logic rst_n,
	input  logic pc_we,
	input  logic take_branch,
	input  cpu_pkg::word_t branch_offset,
	input  logic prog_we,
	input  cpu_pkg::pc_t prog_addr,
	input  cpu_pkg::word_t prog_data,
	input  logic ir_we,
	output cpu_pkg::word_t instr,
	output cpu_pkg::pc_t pc,
	output cpu_pkg::pc_t pc_plus1
);
	import cpu_pkg::*;

	word_t imem [2**IMEM_AW];
	pc_t target;

	assign pc_plus1 = pc + 32'd1;
	assign target = pc + branch_offset;	// relative to the current instruction

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (pc_we) begin
			pc <= take_branch ? target : pc_plus1;
		end
	end

	// load port, only used while the machine sits idle
	always_ff @(posedge CLK) begin
		if (prog_we)
			imem[prog_addr[IMEM_AW-1:0]] <= prog_data;
	end

	always_ff @(posedge CLK) begin
		if (ir_we)
			instr <= imem[pc[IMEM_AW-1:0]];	// instruction register
	end

	a_no_load_while_running: assert property (@(posedge CLK) disable iff (!rst_n)
		!(prog_we && pc_we));

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] pc_t;	// counts instruction words
	typedef logic [4:0] reg_addr_t;
	typedef logic [5:0] opcode_t;

	localparam int IMEM_AW = 8;
	localparam int DMEM_AW = 8;

	// instruction formats, opcode always in [31:26]
	// RALU    rd ra rb, alu op in [3:0]           rd = ra op rb
	// IALU    rd ra imm16                         rd = ra + sext(imm16)
	// LOAD    rd ra imm16                         rd = mem[ra + sext(imm16)]
	// STORE   ra rb off11                         mem[ra + sext(off11)] = rb
	// BRANCH  cond in [14:12], off11 in [10:0]    pc = pc + sext(off11) if cond
	// JAL     rd imm16                            rd = pc + 1, pc = pc + sext(imm16)
	localparam opcode_t OP_RALU   = 6'h01;
	localparam opcode_t OP_IALU   = 6'h02;
	localparam opcode_t OP_LOAD   = 6'h03;
	localparam opcode_t OP_STORE  = 6'h04;
	localparam opcode_t OP_BRANCH = 6'h05;
	localparam opcode_t OP_JAL    = 6'h06;
	localparam opcode_t OP_HALT   = 6'h3f;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR,
		ALU_PASSB
	} alu_op_t;

	typedef enum logic [2:0] {
		COND_AL,	// always
		COND_EQ,	// z
		COND_NE,	// !z
		COND_LT,	// s != o
		COND_CS,	// c
		COND_VS,	// o
		COND_MI,	// s
		COND_NV	// never
	} cond_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_LINK
	} wb_sel_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_DECODE,
		S_EXEC,
		S_MEM,
		S_WB,
		S_HALT
	} state_t;

endpackage
